//--- src/spi_defs.svh
////////////////////////////////////////////////////////////
// Build-time constants for the SPI master with chip select
// SPI mode, serial clock divider, burst length, CS gap
////////////////////////////////////////////////////////////
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// SPI mode 0..3
// Bit 1 is CPOL (idle level of SCLK), bit 0 is CPHA (sample edge)
`define SPI_MODE 1

// System clocks per half serial bit, must be 2 or more
// e.g. 100 MHz i_Clk and 2 gives a 25 MHz SCLK
`define CLKS_PER_HALF_BIT 4

// Largest number of bytes sent while CS is held low
`define MAX_BYTES_PER_CS 4

// Minimum CS high time between bursts, in i_Clk cycles
`define CS_INACTIVE_CLKS 8

// Width of a burst length or byte index
`define SPI_COUNT_W $clog2(`MAX_BYTES_PER_CS + 1)

`endif

//--- src/spi_pkg.sv
////////////////////////////////////////////////////////////
// Shared types for the SPI master
// Data byte, burst count and CS sequencer states
////////////////////////////////////////////////////////////
`default_nettype none

`include "spi_defs.svh"

package spi_pkg;

    ////////////////////////////////////////////////////////////
    // Payload types
    ////////////////////////////////////////////////////////////

    // One byte on MOSI or MISO
    typedef logic [7:0] spi_byte_t;

    // Burst length as given by the user, or position of a byte in a burst
    typedef logic [`SPI_COUNT_W-1:0] spi_count_t;

    ////////////////////////////////////////////////////////////
    // Chip select FSM
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0]
    {
        IDLE     = 2'b00,  // CS high, waiting for first byte
        TRANSFER = 2'b01,  // CS low, bytes moving
        CS_GAP   = 2'b10   // CS high, enforcing minimum inactive time
    } cs_state_t;

endpackage : spi_pkg

`default_nettype wire

//--- src/spi_cs_sequencer.sv
////////////////////////////////////////////////////////////
// Decode stage of the SPI master
// CS FSM, remaining byte count, CS gap timer, user ready
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module spi_cs_sequencer
    import spi_pkg::*;
(
    input  wire logic       i_Clk,
    input  wire logic       i_Rst_L,          // Async, active low
    input  wire spi_count_t i_tx_count,       // Bytes in burst, taken with first dv
    input  wire logic       i_tx_dv,          // One-cycle byte strobe from user
    input  wire logic       i_engine_ready,   // Bit engine can take a byte
    output logic            o_tx_ready,       // User may pulse i_tx_dv
    output logic            o_spi_cs_n        // Chip select, active low
);

    // Gap counter must hold CS_INACTIVE_CLKS, keep at least one bit
    localparam int GAP_W = (`CS_INACTIVE_CLKS > 0) ? $clog2(`CS_INACTIVE_CLKS + 1) : 1;
    localparam logic [GAP_W-1:0] GAP_LOAD = GAP_W'(`CS_INACTIVE_CLKS);

    cs_state_t        r_state;
    spi_count_t       r_bytes_left;    // Bytes still to be handed to the engine
    logic [GAP_W-1:0] r_gap_cnt;       // CS high cycles left before IDLE
    logic             r_cs_n;

    ////////////////////////////////////////////////////////////
    // Chip select state machine
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_Clk or negedge i_Rst_L)
    begin
        if (!i_Rst_L)
        begin
            r_state      <= IDLE;
            r_cs_n       <= 1'b1;       // Bus idle
            r_bytes_left <= '0;
            r_gap_cnt    <= '0;
        end
        else
        begin
            case (r_state)
                IDLE:
                begin
                    // First byte of a burst goes straight to the engine
                    if (i_tx_dv)
                    begin
                        r_bytes_left <= i_tx_count - 1'b1;  // First byte already taken
                        r_cs_n       <= 1'b0;
                        r_state      <= TRANSFER;
                    end
                end

                TRANSFER:
                begin
                    // Engine ready means the previous byte is fully done
                    if (i_engine_ready)
                    begin
                        if (r_bytes_left != '0)
                        begin
                            if (i_tx_dv)
                            begin
                                r_bytes_left <= r_bytes_left - 1'b1;
                            end
                        end
                        else
                        begin
                            r_cs_n    <= 1'b1;      // Burst complete
                            r_gap_cnt <= GAP_LOAD;
                            r_state   <= CS_GAP;
                        end
                    end
                end

                CS_GAP:
                begin
                    // Holds CS high for CS_INACTIVE_CLKS + 1 cycles
                    if (r_gap_cnt != '0)
                    begin
                        r_gap_cnt <= r_gap_cnt - 1'b1;
                    end
                    else
                    begin
                        r_state <= IDLE;
                    end
                end

                default:
                begin
                    r_cs_n  <= 1'b1;    // Recover from illegal encoding
                    r_state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // User side outputs
    ////////////////////////////////////////////////////////////

    // Ready drops in the same cycle as a strobe so no second pulse slips in
    assign o_tx_ready = ((r_state == IDLE) ||
                         ((r_state == TRANSFER) && i_engine_ready && (r_bytes_left != '0)))
                        && !i_tx_dv;

    assign o_spi_cs_n = r_cs_n;

endmodule : spi_cs_sequencer

`default_nettype wire

//--- src/spi_bit_engine.sv
////////////////////////////////////////////////////////////
// Execute stage of the SPI master
// SCLK generation, MOSI shift out, MISO shift in, one byte
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module spi_bit_engine
    import spi_pkg::*;
#(
    parameter int SPI_MODE          = `SPI_MODE,            // 0..3
    parameter int CLKS_PER_HALF_BIT = `CLKS_PER_HALF_BIT    // >= 2
)
(
    input  wire logic      i_Clk,
    input  wire logic      i_Rst_L,
    input  wire spi_byte_t i_tx_byte,       // Byte for MOSI, valid with i_tx_dv
    input  wire logic      i_tx_dv,         // Start strobe
    output logic           o_engine_ready,  // Idle, may start a byte
    output logic           o_bit_dv,        // One cycle, received byte done
    output spi_byte_t      o_bit_byte,      // Byte assembled from MISO
    output logic           o_spi_clk,
    output logic           o_spi_mosi,
    input  wire logic      i_spi_miso
);

    localparam logic CPOL = (SPI_MODE >= 2);        // SCLK idle level
    localparam logic CPHA = ((SPI_MODE % 2) == 1);  // 1 samples on trailing edge

    // Counter spans one full serial bit
    localparam int CNT_W = $clog2(CLKS_PER_HALF_BIT * 2);
    localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_HALF_BIT - 1);
    localparam logic [CNT_W-1:0] FULL_END = CNT_W'(CLKS_PER_HALF_BIT * 2 - 1);

    logic             w_start;       // Accepted start strobe
    logic             w_sample;      // Edge on which MISO is captured
    logic [CNT_W-1:0] r_clk_cnt;     // System clocks within a serial bit
    logic [4:0]       r_edges;       // SCLK edges still to produce, 16 per byte
    logic             r_lead;        // Pulse, leading edge just produced
    logic             r_trail;       // Pulse, trailing edge just produced
    logic             r_spi_clk;
    spi_byte_t        r_tx_byte;     // Copy of byte being sent
    logic [2:0]       r_tx_bit;      // Next bit of r_tx_byte for MOSI
    logic             r_mosi;
    spi_byte_t        r_rx_shift;    // MISO shift register, MSB first

    assign w_start  = i_tx_dv && o_engine_ready;
    assign w_sample = CPHA ? r_trail : r_lead;

    ////////////////////////////////////////////////////////////
    // Ready level
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_Clk or negedge i_Rst_L)
    begin
        if (!i_Rst_L)
            o_engine_ready <= 1'b1;
        else if (w_start)
            o_engine_ready <= 1'b0;     // Busy from the cycle after dv
        else if (o_bit_dv)
            o_engine_ready <= 1'b1;     // Free again right after the result
    end

    ////////////////////////////////////////////////////////////
    // Serial clock and edge pulses
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_Clk or negedge i_Rst_L)
    begin
        if (!i_Rst_L)
        begin
            r_clk_cnt <= '0;
            r_edges   <= '0;
            r_lead    <= 1'b0;
            r_trail   <= 1'b0;
            r_spi_clk <= CPOL;
        end
        else
        begin
            r_lead  <= 1'b0;    // Default, pulses last one cycle
            r_trail <= 1'b0;

            if (w_start)
            begin
                r_edges   <= 5'd16;
                r_clk_cnt <= '0;
            end
            else if (r_edges != '0)
            begin
                if (r_clk_cnt == FULL_END)
                begin
                    // Second half of a bit, back to idle level
                    r_clk_cnt <= '0;
                    r_edges   <= r_edges - 1'b1;
                    r_trail   <= 1'b1;
                    r_spi_clk <= ~r_spi_clk;
                end
                else if (r_clk_cnt == HALF_END)
                begin
                    r_clk_cnt <= r_clk_cnt + 1'b1;
                    r_edges   <= r_edges - 1'b1;
                    r_lead    <= 1'b1;
                    r_spi_clk <= ~r_spi_clk;
                end
                else
                begin
                    r_clk_cnt <= r_clk_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // MOSI, driven on the edge that does not sample
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_Clk or negedge i_Rst_L)
    begin
        if (!i_Rst_L)
        begin
            r_mosi   <= 1'b0;
            r_tx_bit <= 3'd7;
        end
        else if (w_start)
        begin
            if (CPHA)
            begin
                r_tx_bit <= 3'd7;           // MSB goes out on first leading edge
            end
            else
            begin
                r_mosi   <= i_tx_byte[7];   // Phase 0, MSB set up before any edge
                r_tx_bit <= 3'd6;
            end
        end
        else if (CPHA && r_lead)
        begin
            r_mosi   <= r_tx_byte[r_tx_bit];
            r_tx_bit <= r_tx_bit - 1'b1;
        end
        else if (!CPHA && r_trail && (r_edges != '0))
        begin
            // Last trailing edge ends the byte, nothing more to send
            r_mosi   <= r_tx_byte[r_tx_bit];
            r_tx_bit <= r_tx_bit - 1'b1;
        end
    end

    // Payload, no reset
    always_ff @(posedge i_Clk)
    begin
        if (w_start)
            r_tx_byte <= i_tx_byte;
        if (w_sample)
            r_rx_shift <= {r_rx_shift[6:0], i_spi_miso};
    end

    ////////////////////////////////////////////////////////////
    // Done strobe, after the 16th edge so SCLK is idle again
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_Clk or negedge i_Rst_L)
    begin
        if (!i_Rst_L)
            o_bit_dv <= 1'b0;
        else
            o_bit_dv <= r_trail && (r_edges == '0);
    end

    assign o_bit_byte = r_rx_shift;     // Stable until next byte samples
    assign o_spi_clk  = r_spi_clk;
    assign o_spi_mosi = r_mosi;

endmodule : spi_bit_engine

`default_nettype wire

//--- src/spi_rx_collector.sv
////////////////////////////////////////////////////////////
// Result stage of the SPI master
// Registered receive byte, valid strobe, index in burst
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module spi_rx_collector
    import spi_pkg::*;
(
    input  wire logic      i_Clk,
    input  wire logic      i_Rst_L,
    input  wire logic      i_bit_dv,      // Byte done pulse from bit engine
    input  wire spi_byte_t i_bit_byte,
    input  wire logic      i_spi_cs_n,    // High between bursts
    output logic           o_rx_dv,       // One cycle after i_bit_dv
    output spi_byte_t      o_rx_byte,
    output spi_count_t     o_rx_index     // Position of o_rx_byte in burst
);

    spi_count_t r_index;

    // Valid strobe, one cycle late
    always_ff @(posedge i_Clk or negedge i_Rst_L)
    begin
        if (!i_Rst_L)
            o_rx_dv <= 1'b0;
        else
            o_rx_dv <= i_bit_dv;
    end

    always_ff @(posedge i_Clk)
    begin
        if (i_bit_dv)
            o_rx_byte <= i_bit_byte;    // Held until next byte
    end

    // Index advances after each presented byte, restarts with CS high
    always_ff @(posedge i_Clk or negedge i_Rst_L)
    begin
        if (!i_Rst_L)
            r_index <= '0;
        else if (i_spi_cs_n)
            r_index <= '0;
        else if (o_rx_dv)
            r_index <= r_index + 1'b1;
    end

    assign o_rx_index = r_index;

endmodule : spi_rx_collector

`default_nettype wire

//--- src/spi_master_cs_top.sv
////////////////////////////////////////////////////////////
// SPI master with a single chip select
// Sequencer, bit engine and receive collector
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module spi_master_cs_top
    import spi_pkg::*;
(
    input  wire logic       i_Clk,
    input  wire logic       i_Rst_L,

    // User transmit side
    input  wire spi_count_t i_tx_count,    // Burst length, with first i_tx_dv
    input  wire spi_byte_t  i_tx_byte,
    input  wire logic       i_tx_dv,
    output logic            o_tx_ready,

    // User receive side, no back-pressure
    output logic            o_rx_dv,
    output spi_byte_t       o_rx_byte,
    output spi_count_t      o_rx_index,

    // SPI pins
    output logic            o_spi_clk,
    output logic            o_spi_mosi,
    output logic            o_spi_cs_n,
    input  wire logic       i_spi_miso
);

    logic      w_engine_ready;   // Engine idle
    logic      w_bit_dv;         // Engine finished a byte
    spi_byte_t w_bit_byte;

    ////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////
    spi_cs_sequencer u_sequencer
    (
        .i_Clk          (i_Clk),
        .i_Rst_L        (i_Rst_L),
        .i_tx_count     (i_tx_count),
        .i_tx_dv        (i_tx_dv),
        .i_engine_ready (w_engine_ready),
        .o_tx_ready     (o_tx_ready),
        .o_spi_cs_n     (o_spi_cs_n)
    );

    // User strobe and byte go straight to the engine
    spi_bit_engine
    #(
        .SPI_MODE          (`SPI_MODE),
        .CLKS_PER_HALF_BIT (`CLKS_PER_HALF_BIT)
    )
    u_bit_engine
    (
        .i_Clk          (i_Clk),
        .i_Rst_L        (i_Rst_L),
        .i_tx_byte      (i_tx_byte),
        .i_tx_dv        (i_tx_dv),
        .o_engine_ready (w_engine_ready),
        .o_bit_dv       (w_bit_dv),
        .o_bit_byte     (w_bit_byte),
        .o_spi_clk      (o_spi_clk),
        .o_spi_mosi     (o_spi_mosi),
        .i_spi_miso     (i_spi_miso)
    );

    spi_rx_collector u_rx_collector
    (
        .i_Clk      (i_Clk),
        .i_Rst_L    (i_Rst_L),
        .i_bit_dv   (w_bit_dv),
        .i_bit_byte (w_bit_byte),
        .i_spi_cs_n (o_spi_cs_n),   // Clears the burst index
        .o_rx_dv    (o_rx_dv),
        .o_rx_byte  (o_rx_byte),
        .o_rx_index (o_rx_index)
    );

endmodule : spi_master_cs_top

`default_nettype wire

//--- dv/spi_slave_model.sv
////////////////////////////////////////////////////////////
// Behavioral SPI slave for the testbench
// Returns preloaded bytes on MISO, captures bytes from MOSI
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module spi_slave_model
    import spi_pkg::*;
#(
    parameter int SPI_MODE = `SPI_MODE
)
(
    input  wire logic i_spi_clk,
    input  wire logic i_spi_mosi,
    input  wire logic i_spi_cs_n,
    output logic      o_spi_miso
);

    localparam logic CPOL = (SPI_MODE >= 2);
    localparam logic CPHA = ((SPI_MODE % 2) == 1);

    spi_byte_t r_miso_mem [0:`MAX_BYTES_PER_CS];  // Return bytes, one spare slot past the end
    spi_byte_t r_mosi_mem [0:`MAX_BYTES_PER_CS];  // Captured bytes of the current burst
    spi_byte_t r_shift_out;
    spi_byte_t r_shift_in;
    int        r_out_idx;
    int        r_out_cnt;       // Bits of r_shift_out already driven
    int        r_in_idx;        // Bytes captured since CS fell
    int        r_in_cnt;

    // Rises on the leading edge in every mode
    wire w_sck = i_spi_clk ^ CPOL;

    initial
    begin
        o_spi_miso = 1'b0;
        r_in_idx   = 0;
    end

    // Next MISO bit, MSB first, moves to the next byte after eight bits
    task automatic drive_bit();
        if (r_out_cnt == 8)
        begin
            r_out_idx   = r_out_idx + 1;
            r_shift_out = r_miso_mem[r_out_idx];
            r_out_cnt   = 0;
        end
        o_spi_miso  = r_shift_out[7];
        r_shift_out = r_shift_out << 1;
        r_out_cnt   = r_out_cnt + 1;
    endtask

    task automatic sample_bit();
        r_shift_in = {r_shift_in[6:0], i_spi_mosi};
        r_in_cnt   = r_in_cnt + 1;
        if (r_in_cnt == 8)
        begin
            r_mosi_mem[r_in_idx] = r_shift_in;
            r_in_idx             = r_in_idx + 1;
            r_in_cnt             = 0;
        end
    endtask

    // Burst start, phase 0 needs the first MSB before any edge
    always @(negedge i_spi_cs_n)
    begin
        r_out_idx   = 0;
        r_out_cnt   = 0;
        r_in_idx    = 0;
        r_in_cnt    = 0;
        r_shift_out = r_miso_mem[0];
        if (!CPHA)
            drive_bit();
    end

    always @(posedge w_sck)
    begin
        if (i_spi_cs_n == 1'b0)
        begin
            if (CPHA)
                drive_bit();        // Phase 1 drives on the leading edge
            else
                sample_bit();
        end
    end

    always @(negedge w_sck)
    begin
        if (i_spi_cs_n == 1'b0)
        begin
            if (CPHA)
                sample_bit();
            else
                drive_bit();        // Phase 0 drives on the trailing edge
        end
    end

endmodule : spi_slave_model

`default_nettype wire

//--- dv/tb_spi_master_cs.sv
////////////////////////////////////////////////////////////
// Testbench for the SPI master with chip select
// Clock, reset, pattern driver, monitors, compare tasks, watchdog
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module tb_spi_master_cs
    import spi_pkg::*;
();

    localparam int   NUM_BURSTS = 16;
    localparam int   PAT_COLS   = 1 + 2 * `MAX_BYTES_PER_CS;   // Count, tx bytes, rx bytes
    localparam logic CPOL       = (`SPI_MODE >= 2);

    logic       i_Clk;
    logic       i_Rst_L;
    spi_count_t i_tx_count;
    spi_byte_t  i_tx_byte;
    logic       i_tx_dv;
    logic       o_tx_ready;
    logic       o_rx_dv;
    spi_byte_t  o_rx_byte;
    spi_count_t o_rx_index;
    logic       o_spi_clk;
    logic       o_spi_mosi;
    logic       o_spi_cs_n;
    logic       i_spi_miso;

    logic [7:0]  pat_mem [0:NUM_BURSTS*PAT_COLS-1];
    spi_byte_t   exp_rx [0:`MAX_BYTES_PER_CS-1];   // Slave return bytes of the burst in flight
    int          cur_count;
    int          rx_seen;       // Receive strobes seen in this burst
    int          cycle_count;
    int          cycle_limit;
    int          cs_high_cnt;   // Consecutive cycles with CS high
    logic        cs_prev;
    logic        cs_fell_once;
    logic [31:0] rng_state;

    spi_master_cs_top i_dut
    (
        .i_Clk      (i_Clk),
        .i_Rst_L    (i_Rst_L),
        .i_tx_count (i_tx_count),
        .i_tx_byte  (i_tx_byte),
        .i_tx_dv    (i_tx_dv),
        .o_tx_ready (o_tx_ready),
        .o_rx_dv    (o_rx_dv),
        .o_rx_byte  (o_rx_byte),
        .o_rx_index (o_rx_index),
        .o_spi_clk  (o_spi_clk),
        .o_spi_mosi (o_spi_mosi),
        .o_spi_cs_n (o_spi_cs_n),
        .i_spi_miso (i_spi_miso)
    );

    spi_slave_model #(.SPI_MODE(`SPI_MODE)) u_slave
    (
        .i_spi_clk  (o_spi_clk),
        .i_spi_mosi (o_spi_mosi),
        .i_spi_cs_n (o_spi_cs_n),
        .o_spi_miso (i_spi_miso)
    );

    initial
    begin
        i_Clk = 1'b0;
        forever #50 i_Clk = ~i_Clk;     // 100 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_on_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_byte(input string name, input spi_byte_t actual,
                              input spi_byte_t expected);
        if (actual !== expected)
        begin
            $display("** Error %s expected 0x%h actual 0x%h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_index(input string name, input spi_count_t actual,
                               input spi_count_t expected);
        if (actual !== expected)
        begin
            $display("** Error %s expected 0x%h actual 0x%h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_level(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("** Error %s expected 0x%h actual 0x%h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Monitors, sampled mid-cycle
    ////////////////////////////////////////////////////////////
    always @(negedge i_Clk)
    begin
        if (i_Rst_L === 1'b1)
        begin
            if (o_rx_dv)
            begin
                if (rx_seen >= cur_count)
                begin
                    $display("More receive strobes than bytes in the burst");
                    stop_on_failure();
                end
                check_index("o_rx_index", o_rx_index, spi_count_t'(rx_seen));
                check_byte("o_rx_byte", o_rx_byte, exp_rx[rx_seen]);
                rx_seen = rx_seen + 1;
            end
            if (!o_spi_cs_n && cs_prev)
            begin
                if (cs_fell_once && (cs_high_cnt < `CS_INACTIVE_CLKS))
                begin
                    $display("Chip select high for only %0d cycles between bursts", cs_high_cnt);
                    stop_on_failure();
                end
                cs_fell_once = 1'b1;
            end
            if (o_spi_cs_n && !cs_prev && (rx_seen != cur_count))
            begin
                $display("Chip select rose before all bytes of the burst came back");
                stop_on_failure();
            end
            cs_high_cnt = o_spi_cs_n ? cs_high_cnt + 1 : 0;
            cs_prev     = o_spi_cs_n;
        end
    end

    // Watchdog
    always @(posedge i_Clk)
    begin
        if (i_Rst_L === 1'b1)
        begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit)
            begin
                $display("Timeout after %0d cycles, the bursts did not complete", cycle_count);
                stop_on_failure();
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial
    begin
        int b;
        int k;
        int base;
        int count;
        int gap;
        int total_bytes;

        i_Rst_L      = 1'b0;
        i_tx_count   = '0;
        i_tx_byte    = '0;
        i_tx_dv      = 1'b0;
        rng_state    = 32'hfe18f389;
        cur_count    = 0;
        rx_seen      = 0;
        cycle_count  = 0;
        cs_high_cnt  = 0;
        cs_prev      = 1'b1;
        cs_fell_once = 1'b0;

        $readmemh("dv/spi_patterns.txt", pat_mem);
        total_bytes = 0;
        for (b = 0; b < NUM_BURSTS; b++)
        begin
            count = pat_mem[b * PAT_COLS];
            if ((count < 1) || (count > `MAX_BYTES_PER_CS))
            begin
                $display("Pattern line %0d holds an illegal byte count", b);
                stop_on_failure();
            end
            total_bytes = total_bytes + count;
        end
        cycle_limit = total_bytes * (20 * `CLKS_PER_HALF_BIT + 16)
                      + NUM_BURSTS * (`CS_INACTIVE_CLKS + 20);

        repeat (5) @(negedge i_Clk);
        i_Rst_L = 1'b1;
        @(negedge i_Clk);
        check_level("o_spi_cs_n", o_spi_cs_n, 1'b1);
        check_level("o_tx_ready", o_tx_ready, 1'b1);
        check_level("o_rx_dv", o_rx_dv, 1'b0);
        check_level("o_spi_clk", o_spi_clk, CPOL);

        for (b = 0; b < NUM_BURSTS; b++)
        begin
            base  = b * PAT_COLS;
            count = pat_mem[base];
            for (k = 0; k < count; k++)
            begin
                u_slave.r_miso_mem[k] = pat_mem[base + 1 + `MAX_BYTES_PER_CS + k];
                exp_rx[k]             = pat_mem[base + 1 + `MAX_BYTES_PER_CS + k];
            end
            cur_count = count;
            rx_seen   = 0;

            for (k = 0; k < count; k++)
            begin
                while (!o_tx_ready)
                    @(negedge i_Clk);
                rng_state = xorshift32(rng_state);
                gap       = rng_state[2:0];     // 0 to 7 idle cycles
                repeat (gap) @(negedge i_Clk);
                i_tx_count = spi_count_t'(count);
                i_tx_byte  = pat_mem[base + 1 + k];
                i_tx_dv    = 1'b1;
                @(negedge i_Clk);
                i_tx_dv    = 1'b0;
            end

            // Burst done once all bytes are back and the CS gap has passed
            while ((rx_seen < cur_count) || !o_spi_cs_n || !o_tx_ready)
                @(negedge i_Clk);

            check_index("slave byte count", spi_count_t'(u_slave.r_in_idx),
                        spi_count_t'(count));
            for (k = 0; k < count; k++)
                check_byte("o_spi_mosi", u_slave.r_mosi_mem[k], pat_mem[base + 1 + k]);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule : tb_spi_master_cs

`default_nettype wire

//--- sim.f
+incdir+src
src/spi_pkg.sv
src/spi_cs_sequencer.sv
src/spi_bit_engine.sv
src/spi_rx_collector.sv
src/spi_master_cs_top.sv
dv/spi_slave_model.sv
dv/tb_spi_master_cs.sv

//--- dv/spi_patterns.txt
// One burst per line, hex: count, tx0 tx1 tx2 tx3, rx0 rx1 rx2 rx3
// tx goes out on MOSI, rx is what the slave returns, unused bytes are 00
01 a5 00 00 00 5a 00 00 00
04 01 02 04 08 80 40 20 10
02 ff 00 00 00 00 ff 00 00
03 3c c3 96 00 69 f0 0f 00
04 de ad be ef ca fe f0 0d
01 00 00 00 00 ff 00 00 00
01 ff 00 00 00 00 00 00 00
02 55 aa 00 00 aa 55 00 00
04 12 34 56 78 87 65 43 21
03 80 01 7e 00 01 80 e7 00
01 c9 00 00 00 9c 00 00 00
04 ff 00 ff 00 00 ff 00 ff
02 6d b7 00 00 d2 4b 00 00
04 a1 b2 c3 d4 e5 f6 07 18
03 0f f0 5a 00 a5 0f f0 00
01 81 00 00 00 7e 00 00 00
